// File: hdl/dmmu_pkg.sv
package dmmu_pkg;

  // ========================================================================
  // address and field widths, Sv39
  // ========================================================================
  localparam int VLEN        = 39;
  localparam int PLEN        = 56;
  localparam int XLEN        = 64;
  localparam int PPNW        = 44;
  localparam int VPNW        = 27;
  localparam int ASIDW       = 16;
  localparam int TLB_ENTRIES = 8;
  localparam int CAUSEW      = 6;

  // exception causes reported to the LSU
  localparam logic [CAUSEW-1:0] LD_ADDR_MISALIGNED = 6'd4;
  localparam logic [CAUSEW-1:0] ST_ADDR_MISALIGNED = 6'd6;
  localparam logic [CAUSEW-1:0] LD_PAGE_FAULT      = 6'd13;
  localparam logic [CAUSEW-1:0] ST_PAGE_FAULT      = 6'd15;

  localparam logic [1:0] PRIV_U = 2'd0;
  localparam logic [1:0] PRIV_S = 2'd1;

  // refill word, seen raw or as Sv39 PTE fields
  typedef union packed {
    logic [63:0] raw;
    struct packed {
      logic [9:0]      reserved;
      logic [PPNW-1:0] ppn;
      logic [1:0]      rsw;
      logic            d;     // dirty
      logic            a;     // accessed
      logic            g;     // global, ignores asid
      logic            u;     // user page
      logic            x;
      logic            w;
      logic            r;
      logic            v;
    } fields;
  } pte_u;

endpackage

// File: hdl/dtlb_lookup_if.sv
`timescale 1ns/100ps

interface dtlb_lookup_if import dmmu_pkg::*; ();

  logic             access;   // lookup strobe
  logic [VLEN-1:0]  vaddr;
  logic [ASIDW-1:0] asid;
  logic             hit;      // same cycle as access
  pte_u             pte;
  logic [1:0]       is_page;  // [1] 1 GiB, [0] 2 MiB

  // translation stage side
  modport requester (
    output access, vaddr, asid,
    input  hit, pte, is_page
  );

  // tlb side, answers combinationally
  modport responder (
    input  access, vaddr, asid,
    output hit, pte, is_page
  );

endinterface

// File: hdl/dtlb.sv
`timescale 1ns/100ps

module dtlb import dmmu_pkg::*; (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 flush_tlb_i,
  input  logic                 update_valid_i,
  input  logic [VPNW-1:0]      update_vpn_i,
  input  logic [ASIDW-1:0]     update_asid_i,
  input  logic [1:0]           update_is_page_i,
  input  pte_u                 update_pte_i,
  dtlb_lookup_if.responder     lookup
);

  // ========================================================================
  // entry storage
  // ========================================================================
  logic [TLB_ENTRIES-1:0]     valid_q;
  logic [VPNW-1:0]            vpn_q     [TLB_ENTRIES];
  logic [ASIDW-1:0]           asid_q    [TLB_ENTRIES];
  logic [1:0]                 is_page_q [TLB_ENTRIES];
  pte_u                       pte_q     [TLB_ENTRIES];
  logic [$clog2(TLB_ENTRIES)-1:0] rr_q;  // next victim

  logic [TLB_ENTRIES-1:0] match;
  pte_u                   lu_pte;
  logic [1:0]             lu_is_page;

  // valid bits and replacement pointer
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= '0;
      rr_q    <= '0;
    end else if (flush_tlb_i) begin
      valid_q <= '0;  // global entries go too, refill dropped
    end else if (update_valid_i) begin
      valid_q[rr_q] <= 1'b1;
      rr_q          <= rr_q + 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (update_valid_i && !flush_tlb_i) begin
      vpn_q[rr_q]     <= update_vpn_i;
      asid_q[rr_q]    <= update_asid_i;
      is_page_q[rr_q] <= update_is_page_i;
      pte_q[rr_q]     <= update_pte_i;
    end
  end

  // ========================================================================
  // fully associative match
  // ========================================================================
  always_comb begin
    for (int i = 0; i < TLB_ENTRIES; i++) begin
      match[i] = valid_q[i]
        && (lookup.vaddr[38:30] == vpn_q[i][26:18])
        && (is_page_q[i][1] || lookup.vaddr[29:21] == vpn_q[i][17:9])
        && (|is_page_q[i] || lookup.vaddr[20:12] == vpn_q[i][8:0])
        && (pte_q[i].fields.g || lookup.asid == asid_q[i]);
    end
  end

  always_comb begin
    lu_pte     = '0;
    lu_is_page = '0;
    for (int i = 0; i < TLB_ENTRIES; i++) begin
      if (match[i]) begin
        lu_pte     = pte_q[i];
        lu_is_page = is_page_q[i];
      end
    end
  end

  assign lookup.hit     = lookup.access && (|match);
  assign lookup.pte     = lu_pte;
  assign lookup.is_page = lu_is_page;

  // overlapping entries would make the pte mux ambiguous
  a_single_match : assert property (
    @(posedge clk_i) disable iff (!rst_ni) $onehot0(match)
  ) else $error("dtlb: more than one entry matches");

endmodule

// File: hdl/dmmu_xlate_stage.sv
`timescale 1ns/100ps

module dmmu_xlate_stage import dmmu_pkg::*; (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              en_ld_st_translation_i,
  input  logic              lsu_req_i,
  input  logic [VLEN-1:0]   lsu_vaddr_i,
  input  logic              lsu_is_store_i,
  input  logic              misaligned_i,
  input  logic [1:0]        ld_st_priv_lvl_i,
  input  logic              sum_i,
  input  logic [ASIDW-1:0]  asid_i,
  dtlb_lookup_if.requester  lookup,
  output logic              lsu_dtlb_hit_o,
  output logic [PPNW-1:0]   lsu_dtlb_ppn_o,
  output logic              lsu_valid_o,
  output logic [PLEN-1:0]   lsu_paddr_o,
  output logic              exception_valid_o,
  output logic [CAUSEW-1:0] exception_cause_o,
  output logic [XLEN-1:0]   exception_tval_o,
  output logic              dtlb_miss_o
);

  // control, reset
  logic req_q, en_q, misaligned_q, hit_q;
  // payload
  logic [VLEN-1:0] vaddr_q;
  logic            is_store_q;
  logic [1:0]      priv_q;
  logic            sum_q;
  pte_u            pte_q;
  logic [1:0]      is_page_q;

  logic daccess;
  logic page_fault;

  // ========================================================================
  // request cycle: lookup and same-cycle answer
  // ========================================================================
  assign lookup.access = lsu_req_i && !misaligned_i;
  assign lookup.vaddr  = lsu_vaddr_i;
  assign lookup.asid   = asid_i;

  assign lsu_dtlb_hit_o = en_ld_st_translation_i ? lookup.hit : 1'b1;
  assign dtlb_miss_o    = en_ld_st_translation_i && lookup.access && !lookup.hit;

  always_comb begin
    lsu_dtlb_ppn_o = PPNW'(lsu_vaddr_i[VLEN-1:12]);  // bare mode
    if (en_ld_st_translation_i) begin
      lsu_dtlb_ppn_o = lookup.pte.fields.ppn;
      if (lookup.is_page[0]) lsu_dtlb_ppn_o[8:0] = lsu_vaddr_i[20:12];
      if (lookup.is_page[1]) lsu_dtlb_ppn_o[17:0] = lsu_vaddr_i[29:12];
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      req_q        <= 1'b0;
      en_q         <= 1'b0;
      misaligned_q <= 1'b0;
      hit_q        <= 1'b0;
    end else begin
      req_q        <= lsu_req_i;
      en_q         <= en_ld_st_translation_i;
      misaligned_q <= lsu_req_i && misaligned_i;
      hit_q        <= lookup.hit;
    end
  end

  always_ff @(posedge clk_i) begin
    vaddr_q     <= lsu_vaddr_i;
    is_store_q  <= lsu_is_store_i;
    priv_q      <= ld_st_priv_lvl_i;
    sum_q       <= sum_i;
    pte_q       <= lookup.pte;
    is_page_q   <= lookup.is_page;
  end

  // ========================================================================
  // output cycle: address and exceptions
  // ========================================================================
  assign lsu_valid_o = req_q && (!en_q || misaligned_q || hit_q);

  always_comb begin
    lsu_paddr_o = PLEN'(vaddr_q);
    if (en_q && !misaligned_q) begin
      lsu_paddr_o = {pte_q.fields.ppn, vaddr_q[11:0]};
      if (is_page_q[0]) lsu_paddr_o[20:12] = vaddr_q[20:12];  // 2 MiB
      if (is_page_q[1]) lsu_paddr_o[29:12] = vaddr_q[29:12];  // 1 GiB
    end
  end

  assign daccess = (priv_q == PRIV_S && !sum_q && pte_q.fields.u)
                || (priv_q == PRIV_U && !pte_q.fields.u);

  assign page_fault = daccess
                   || (is_store_q && (!pte_q.fields.w || !pte_q.fields.d));

  always_comb begin
    exception_valid_o = 1'b0;
    exception_cause_o = '0;
    exception_tval_o  = '0;
    if (req_q && misaligned_q) begin
      exception_valid_o = 1'b1;
      exception_cause_o = is_store_q ? ST_ADDR_MISALIGNED : LD_ADDR_MISALIGNED;
    end else if (req_q && en_q && hit_q && page_fault) begin
      exception_valid_o = 1'b1;
      exception_cause_o = is_store_q ? ST_PAGE_FAULT : LD_PAGE_FAULT;
    end
    if (exception_valid_o) begin
      exception_tval_o = {{(XLEN-VLEN){vaddr_q[VLEN-1]}}, vaddr_q};
    end
  end

  // payload registers have no reset, a valid answer must not carry unknown bits
  a_valid_known : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
      lsu_valid_o |-> !$isunknown({lsu_paddr_o, exception_valid_o, exception_cause_o})
  ) else $error("dmmu: unknown paddr or exception with lsu_valid_o");

endmodule

// File: hdl/dmmu_top.sv
`timescale 1ns/100ps

module dmmu_top import dmmu_pkg::*; (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              en_ld_st_translation_i,
  input  logic              flush_tlb_i,
  // lsu request
  input  logic              lsu_req_i,
  input  logic [VLEN-1:0]   lsu_vaddr_i,
  input  logic              lsu_is_store_i,
  input  logic              misaligned_i,
  input  logic [1:0]        ld_st_priv_lvl_i,
  input  logic              sum_i,
  input  logic [ASIDW-1:0]  asid_i,
  // refill
  input  logic              update_valid_i,
  input  logic [VPNW-1:0]   update_vpn_i,
  input  logic [ASIDW-1:0]  update_asid_i,
  input  logic [1:0]        update_is_page_i,
  input  pte_u              update_pte_i,
  // lsu response
  output logic              lsu_dtlb_hit_o,
  output logic [PPNW-1:0]   lsu_dtlb_ppn_o,
  output logic              lsu_valid_o,
  output logic [PLEN-1:0]   lsu_paddr_o,
  output logic              exception_valid_o,
  output logic [CAUSEW-1:0] exception_cause_o,
  output logic [XLEN-1:0]   exception_tval_o,
  output logic              dtlb_miss_o
);

  dtlb_lookup_if u_lookup_if ();

  dtlb u_dtlb (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .flush_tlb_i      (flush_tlb_i),
    .update_valid_i   (update_valid_i),
    .update_vpn_i     (update_vpn_i),
    .update_asid_i    (update_asid_i),
    .update_is_page_i (update_is_page_i),
    .update_pte_i     (update_pte_i),
    .lookup           (u_lookup_if.responder)
  );

  dmmu_xlate_stage u_xlate (
    .clk_i                  (clk_i),
    .rst_ni                 (rst_ni),
    .en_ld_st_translation_i (en_ld_st_translation_i),
    .lsu_req_i              (lsu_req_i),
    .lsu_vaddr_i            (lsu_vaddr_i),
    .lsu_is_store_i         (lsu_is_store_i),
    .misaligned_i           (misaligned_i),
    .ld_st_priv_lvl_i       (ld_st_priv_lvl_i),
    .sum_i                  (sum_i),
    .asid_i                 (asid_i),
    .lookup                 (u_lookup_if.requester),
    .lsu_dtlb_hit_o         (lsu_dtlb_hit_o),
    .lsu_dtlb_ppn_o         (lsu_dtlb_ppn_o),
    .lsu_valid_o            (lsu_valid_o),
    .lsu_paddr_o            (lsu_paddr_o),
    .exception_valid_o      (exception_valid_o),
    .exception_cause_o      (exception_cause_o),
    .exception_tval_o       (exception_tval_o),
    .dtlb_miss_o            (dtlb_miss_o)
  );

endmodule

// File: verification/dmmu_tb_table.svh
`ifndef DMMU_TB_TABLE_SVH
`define DMMU_TB_TABLE_SVH

// refill entry: vpn, asid, page size, pte
typedef struct {
  logic [VPNW-1:0]  vpn;
  logic [ASIDW-1:0] asid;
  logic [1:0]       is_page;
  pte_u             pte;
} refill_t;

// op 0 is a request, 1 a refill of refills[idx], 2 a flush
typedef struct {
  string            name;
  int               op;
  int               idx;
  logic             en;
  logic [VPNW-1:0]  vpn;
  logic             store;
  logic             mis;
  logic [1:0]       priv;
  logic             sum;
  logic [ASIDW-1:0] asid;
  bit               rnd_priv;  // random privilege and sum
  int               off_bits;  // random low vaddr bits
} row_t;

localparam int N_INIT = 6;  // refills written before the table

refill_t refills[$];
row_t    rows[$];
bit      model_valid [TLB_ENTRIES];

function automatic pte_u make_pte(input logic [PPNW-1:0] ppn, input logic g, input logic u,
                                  input logic w, input logic d);
  pte_u p;
  p.raw          = '0;
  p.fields.ppn   = ppn;
  p.fields.g     = g;
  p.fields.u     = u;
  p.fields.w     = w;
  p.fields.d     = d;
  p.fields.v     = 1'b1;
  p.fields.r     = 1'b1;
  p.fields.a     = 1'b1;
  return p;
endfunction

task automatic add_refill(input logic [VPNW-1:0] vpn, input logic [ASIDW-1:0] asid,
                          input logic [1:0] is_page, input pte_u pte);
  refill_t e;
  e.vpn     = vpn;
  e.asid    = asid;
  e.is_page = is_page;
  e.pte     = pte;
  refills.push_back(e);
endtask

task automatic add_row(input string name, input int op, input int idx, input logic en,
                       input logic [VPNW-1:0] vpn, input logic store, input logic mis,
                       input logic [1:0] priv, input logic sum, input logic [ASIDW-1:0] asid,
                       input bit rnd_priv, input int off_bits);
  row_t r;
  r.name     = name;
  r.op       = op;
  r.idx      = idx;
  r.en       = en;
  r.vpn      = vpn;
  r.store    = store;
  r.mis      = mis;
  r.priv     = priv;
  r.sum      = sum;
  r.asid     = asid;
  r.rnd_priv = rnd_priv;
  r.off_bits = off_bits;
  rows.push_back(r);
endtask

task automatic build_tables();
  // ==========================================================================
  // refill list, no two entries overlap
  // ==========================================================================
  add_refill({9'd1, 9'd2, 9'd3}, 16'd5, 2'b00, make_pte(44'h12345, 0, 0, 1, 1));
  add_refill({9'd4, 9'h10, 9'd0}, 16'd5, 2'b01, make_pte(44'h40200, 0, 0, 1, 1));
  add_refill({9'd8, 9'd0, 9'd0}, 16'd0, 2'b10, make_pte(44'h80000, 1, 0, 1, 1));  // global
  add_refill({9'd1, 9'd2, 9'd4}, 16'd5, 2'b00, make_pte(44'h00444, 0, 0, 0, 1));  // read only
  add_refill({9'd1, 9'd2, 9'd5}, 16'd5, 2'b00, make_pte(44'h00555, 0, 0, 1, 0));  // not dirty
  add_refill({9'd1, 9'd2, 9'd6}, 16'd5, 2'b00, make_pte(44'h00666, 0, 1, 1, 1));  // user
  add_refill({9'd1, 9'd2, 9'd7}, 16'd5, 2'b00, make_pte(44'h00777, 0, 0, 1, 1));  // late
  // ==========================================================================
  // request table
  // ==========================================================================
  add_row("bare_load", 0, 0, 0, {9'h1ff, 9'd3, 9'd9}, 0, 0, PRIV_S, 0, 16'd5, 1, 12);
  add_row("bare_store", 0, 0, 0, {9'd2, 9'd3, 9'd9}, 1, 0, PRIV_U, 0, 16'd5, 0, 12);
  add_row("hit_4k_load", 0, 0, 1, {9'd1, 9'd2, 9'd3}, 0, 0, PRIV_S, 0, 16'd5, 0, 12);
  add_row("hit_4k_store", 0, 0, 1, {9'd1, 9'd2, 9'd3}, 1, 0, PRIV_S, 0, 16'd5, 0, 12);
  add_row("hit_2m_load", 0, 0, 1, {9'd4, 9'h10, 9'd0}, 0, 0, PRIV_S, 0, 16'd5, 0, 21);
  add_row("hit_1g_global", 0, 0, 1, {9'd8, 9'd0, 9'd0}, 0, 0, PRIV_S, 0, 16'd9, 0, 30);
  add_row("miss_asid", 0, 0, 1, {9'd1, 9'd2, 9'd3}, 0, 0, PRIV_S, 0, 16'd9, 0, 12);
  add_row("miss_page", 0, 0, 1, {9'd1, 9'd2, 9'd7}, 0, 0, PRIV_S, 0, 16'd5, 0, 12);
  add_row("refill_late", 1, 6, 0, '0, 0, 0, PRIV_S, 0, 16'd5, 0, 12);
  add_row("hit_after_refill", 0, 0, 1, {9'd1, 9'd2, 9'd7}, 0, 0, PRIV_S, 0, 16'd5, 0, 12);
  add_row("st_read_only", 0, 0, 1, {9'd1, 9'd2, 9'd4}, 1, 0, PRIV_S, 0, 16'd5, 0, 12);
  add_row("st_not_dirty", 0, 0, 1, {9'd1, 9'd2, 9'd5}, 1, 0, PRIV_S, 0, 16'd5, 0, 12);
  add_row("ld_read_only", 0, 0, 1, {9'd1, 9'd2, 9'd4}, 0, 0, PRIV_S, 0, 16'd5, 1, 12);
  add_row("u_on_s_page", 0, 0, 1, {9'd1, 9'd2, 9'd3}, 0, 0, PRIV_U, 0, 16'd5, 0, 12);
  add_row("s_on_u_sum0", 0, 0, 1, {9'd1, 9'd2, 9'd6}, 0, 0, PRIV_S, 0, 16'd5, 0, 12);
  add_row("s_on_u_sum1", 0, 0, 1, {9'd1, 9'd2, 9'd6}, 0, 0, PRIV_S, 1, 16'd5, 0, 12);
  add_row("u_on_u_page", 0, 0, 1, {9'd1, 9'd2, 9'd6}, 1, 0, PRIV_U, 0, 16'd5, 0, 12);
  add_row("rnd_user_page", 0, 0, 1, {9'd1, 9'd2, 9'd6}, 0, 0, PRIV_S, 0, 16'd5, 1, 12);
  add_row("rnd_2m_page", 0, 0, 1, {9'd4, 9'h10, 9'd0}, 1, 0, PRIV_S, 0, 16'd5, 1, 21);
  add_row("mis_ld_xlate", 0, 0, 1, {9'd1, 9'd2, 9'd3}, 0, 1, PRIV_S, 0, 16'd5, 0, 12);
  add_row("mis_st_bare", 0, 0, 0, {9'h100, 9'd2, 9'd3}, 1, 1, PRIV_S, 0, 16'd5, 0, 12);
  add_row("mis_st_no_page", 0, 0, 1, {9'd1, 9'd2, 9'd9}, 1, 1, PRIV_S, 0, 16'd5, 0, 12);
  add_row("flush", 2, 0, 0, '0, 0, 0, PRIV_S, 0, 16'd5, 0, 12);
  add_row("miss_after_flush", 0, 0, 1, {9'd1, 9'd2, 9'd3}, 0, 0, PRIV_S, 0, 16'd5, 0, 12);
  add_row("miss_1g_flushed", 0, 0, 1, {9'd8, 9'd0, 9'd0}, 0, 0, PRIV_S, 0, 16'd9, 0, 30);
endtask

// expected response of one request from the model of the refilled entries
function automatic void expect_resp(
  input row_t r, input logic [VLEN-1:0] va,
  output logic hit, output logic [PPNW-1:0] ppn_o, output logic miss, output logic valid,
  output logic [PLEN-1:0] paddr, output logic exc, output logic [CAUSEW-1:0] cause,
  output logic [XLEN-1:0] tval);
  int              m;
  logic            access;
  logic            fault;
  logic [PPNW-1:0] ppn;
  pte_u            p;
  m      = -1;
  access = !r.mis;
  p.raw  = '0;
  ppn    = '0;
  for (int i = 0; i < refills.size(); i++) begin
    if (model_valid[i] && va[38:30] == refills[i].vpn[26:18]
        && (refills[i].is_page[1] || va[29:21] == refills[i].vpn[17:9])
        && ((|refills[i].is_page) || va[20:12] == refills[i].vpn[8:0])
        && (refills[i].pte.fields.g || r.asid == refills[i].asid)) begin
      m = i;
    end
  end
  if (m >= 0) begin
    p   = refills[m].pte;
    ppn = p.fields.ppn;
    if (refills[m].is_page[0]) ppn[8:0] = va[20:12];
    if (refills[m].is_page[1]) ppn[17:0] = va[29:12];
  end
  hit   = r.en ? (access && m >= 0) : 1'b1;
  ppn_o = r.en ? ppn : PPNW'(va[VLEN-1:12]);
  miss  = r.en && access && m < 0;
  valid = !r.en || r.mis || (access && m >= 0);
  paddr = (!r.en || r.mis) ? PLEN'(va) : {ppn, va[11:0]};
  exc   = 1'b0;
  cause = '0;
  tval  = '0;
  if (r.mis) begin
    exc   = 1'b1;
    cause = r.store ? ST_ADDR_MISALIGNED : LD_ADDR_MISALIGNED;
  end else if (r.en && m >= 0) begin
    fault = (r.priv == PRIV_S && !r.sum && p.fields.u) || (r.priv == PRIV_U && !p.fields.u)
         || (r.store && !(p.fields.w && p.fields.d));
    if (fault) begin
      exc   = 1'b1;
      cause = r.store ? ST_PAGE_FAULT : LD_PAGE_FAULT;
    end
  end
  if (exc) tval = {{(XLEN-VLEN){va[VLEN-1]}}, va};
endfunction

`endif

// File: verification/dmmu_tb.sv
`timescale 1ns/100ps

module dmmu_tb import dmmu_pkg::*; ();

  logic              clk_i;
  logic              rst_ni;
  logic              en_ld_st_translation_i;
  logic              flush_tlb_i;
  logic              lsu_req_i;
  logic [VLEN-1:0]   lsu_vaddr_i;
  logic              lsu_is_store_i;
  logic              misaligned_i;
  logic [1:0]        ld_st_priv_lvl_i;
  logic              sum_i;
  logic [ASIDW-1:0]  asid_i;
  logic              update_valid_i;
  logic [VPNW-1:0]   update_vpn_i;
  logic [ASIDW-1:0]  update_asid_i;
  logic [1:0]        update_is_page_i;
  pte_u              update_pte_i;
  logic              lsu_dtlb_hit_o;
  logic [PPNW-1:0]   lsu_dtlb_ppn_o;
  logic              lsu_valid_o;
  logic [PLEN-1:0]   lsu_paddr_o;
  logic              exception_valid_o;
  logic [CAUSEW-1:0] exception_cause_o;
  logic [XLEN-1:0]   exception_tval_o;
  logic              dtlb_miss_o;

  logic [31:0] rng_state;
  bit          tables_ready;

  `include "dmmu_tb_table.svh"

  dmmu_top DUT (.*);

  initial clk_i = 1'b0;
  always #2 clk_i = ~clk_i;  // 4 ns

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] s;
    s = x;
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("TEST FAILED");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_bit(input string name, input string what, input logic exp,
                           input logic act);
    if (act !== exp)
      stop_on_error($sformatf("MISMATCH %s %s expected %0b actual %0b", name, what, exp, act));
  endtask

  task automatic check_ppn(input string name, input logic [PPNW-1:0] exp,
                           input logic [PPNW-1:0] act);
    if (act !== exp)
      stop_on_error($sformatf("MISMATCH %s ppn expected %0h actual %0h", name, exp, act));
  endtask

  task automatic check_paddr(input string name, input logic [PLEN-1:0] exp,
                             input logic [PLEN-1:0] act);
    if (act !== exp)
      stop_on_error($sformatf("MISMATCH %s paddr expected %0h actual %0h", name, exp, act));
  endtask

  task automatic check_cause(input string name, input logic [CAUSEW-1:0] exp,
                             input logic [CAUSEW-1:0] act);
    if (act !== exp)
      stop_on_error($sformatf("MISMATCH %s cause expected %0d actual %0d", name, exp, act));
  endtask

  task automatic check_tval(input string name, input logic [XLEN-1:0] exp,
                            input logic [XLEN-1:0] act);
    if (act !== exp)
      stop_on_error($sformatf("MISMATCH %s tval expected %0h actual %0h", name, exp, act));
  endtask

  task automatic apply_refill(input int idx);
    @(posedge clk_i);
    #1;
    update_valid_i   = 1'b1;
    update_vpn_i     = refills[idx].vpn;
    update_asid_i    = refills[idx].asid;
    update_is_page_i = refills[idx].is_page;
    update_pte_i     = refills[idx].pte;
    @(posedge clk_i);
    #1 update_valid_i = 1'b0;
    model_valid[idx] = 1'b1;
  endtask

  task automatic apply_flush();
    @(posedge clk_i);
    #1 flush_tlb_i = 1'b1;
    @(posedge clk_i);
    #1 flush_tlb_i = 1'b0;
    for (int i = 0; i < TLB_ENTRIES; i++) model_valid[i] = 1'b0;
  endtask

  // ==========================================================================
  // one request, lookup cycle then output cycle
  // ==========================================================================
  task automatic run_request(input row_t row);
    row_t              r;
    logic [VLEN-1:0]   va;
    logic              e_hit, e_miss, e_valid, e_exc;
    logic [PPNW-1:0]   e_ppn;
    logic [PLEN-1:0]   e_paddr;
    logic [CAUSEW-1:0] e_cause;
    logic [XLEN-1:0]   e_tval;
    r         = row;
    rng_state = xorshift32(rng_state);
    va        = {r.vpn, 12'h000} | (VLEN'(rng_state) & ((VLEN'(1) << r.off_bits) - VLEN'(1)));
    if (r.rnd_priv) begin
      rng_state = xorshift32(rng_state);
      r.priv    = rng_state[0] ? PRIV_S : PRIV_U;
      r.sum     = rng_state[1];
    end
    expect_resp(r, va, e_hit, e_ppn, e_miss, e_valid, e_paddr, e_exc, e_cause, e_tval);
    @(posedge clk_i);
    #1;
    lsu_req_i              = 1'b1;
    lsu_vaddr_i            = va;
    en_ld_st_translation_i = r.en;
    lsu_is_store_i         = r.store;
    misaligned_i           = r.mis;
    ld_st_priv_lvl_i       = r.priv;
    sum_i                  = r.sum;
    asid_i                 = r.asid;
    #2;
    check_bit(r.name, "hit", e_hit, lsu_dtlb_hit_o);
    check_bit(r.name, "miss", e_miss, dtlb_miss_o);
    if (e_hit) check_ppn(r.name, e_ppn, lsu_dtlb_ppn_o);
    @(posedge clk_i);
    #1 lsu_req_i = 1'b0;
    #2;
    check_bit(r.name, "miss pulse end", 1'b0, dtlb_miss_o);
    check_bit(r.name, "valid", e_valid, lsu_valid_o);
    if (e_valid) check_paddr(r.name, e_paddr, lsu_paddr_o);
    check_bit(r.name, "exception", e_exc, exception_valid_o);
    check_cause(r.name, e_cause, exception_cause_o);
    check_tval(r.name, e_tval, exception_tval_o);
  endtask

  initial begin
    rst_ni                 = 1'b0;
    en_ld_st_translation_i = 1'b0;
    flush_tlb_i            = 1'b0;
    lsu_req_i              = 1'b0;
    lsu_vaddr_i            = '0;
    lsu_is_store_i         = 1'b0;
    misaligned_i           = 1'b0;
    ld_st_priv_lvl_i       = PRIV_S;
    sum_i                  = 1'b0;
    asid_i                 = '0;
    update_valid_i         = 1'b0;
    update_vpn_i           = '0;
    update_asid_i          = '0;
    update_is_page_i       = '0;
    update_pte_i           = '0;
    rng_state              = 32'd1;
    build_tables();
    tables_ready = 1'b1;
    repeat (10) @(posedge clk_i);
    #1 rst_ni = 1'b1;
    #2;
    check_bit("after_reset", "valid", 1'b0, lsu_valid_o);
    check_bit("after_reset", "exception", 1'b0, exception_valid_o);
    check_bit("after_reset", "miss", 1'b0, dtlb_miss_o);
    for (int i = 0; i < N_INIT; i++) apply_refill(i);
    for (int n = 0; n < rows.size(); n++) begin
      if (rows[n].op == 1) apply_refill(rows[n].idx);
      else if (rows[n].op == 2) apply_flush();
      else run_request(rows[n]);
    end
    $display("TEST OK");
    $finish;
  end

  // watchdog, four times the expected run length
  initial begin
    realtime limit;
    wait (tables_ready);
    limit = (refills.size() + rows.size() + 20) * 4.0 * 4.0;
    #(limit);
    $display("timeout: the table did not finish in %0t", $realtime);
    $display("TEST FAILED");
    $fatal(1, "watchdog expired");
  end

endmodule

// File: dmmu.f
+incdir+verification
hdl/dmmu_pkg.sv
hdl/dtlb_lookup_if.sv
hdl/dtlb.sv
hdl/dmmu_xlate_stage.sv
hdl/dmmu_top.sv
verification/dmmu_tb.sv

// File: Makefile
SIM    = verilator
FLAGS  = --binary --timing -j 0
TOP    = dmmu_tb
FLIST  = dmmu.f
OBJDIR = obj_dir

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(OBJDIR)
	@out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "TEST OK"

clean:
	rm -rf $(OBJDIR)
